// ==== src/obi_pkg.sv ====
// bus field widths
// request and response structs for the request/grant/rvalid handshake

package obi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // master to slave, 70 bits
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } obi_req_t;

  // slave to master, 34 bits
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } obi_resp_t;

endpackage

// ==== src/mcu_pkg.sv ====
// address map and region sizes
// peripheral register offsets, slave select encoding

package mcu_pkg;

  // on-chip sram
  localparam logic [31:0] RAM_START      = 32'h0000_0000;
  localparam logic [31:0] RAM_SIZE       = 32'h0000_1000;

  // slow memory, 128 words
  localparam logic [31:0] SLOW_RAM_START = 32'h0001_0000;
  localparam logic [31:0] SLOW_RAM_SIZE  = 32'h0000_0200;

  // exit peripheral
  localparam logic [31:0] PERIPH_START   = 32'h0002_0000;
  localparam logic [31:0] PERIPH_SIZE    = 32'h0000_1000;

  // offsets inside the peripheral region
  localparam logic [31:0] EXIT_VALUE_OFFSET = 32'h0;
  localparam logic [31:0] EXIT_VALID_OFFSET = 32'h4;
  localparam logic [31:0] SCRATCH_OFFSET    = 32'h8;

  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_SLOW,
    SEL_PERIPH,
    SEL_NONE
  } slave_sel_e;

endpackage

// ==== src/system_bus.sv ====
// address decoder and router for one master and three slaves
// single outstanding transaction, response steered by registered select

module system_bus
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  obi_req_t  master_req_i,
  output obi_resp_t master_resp_o,

  output obi_req_t  ram_req_o,
  input  obi_resp_t ram_resp_i,
  output obi_req_t  slow_req_o,
  input  obi_resp_t slow_resp_i,
  output obi_req_t  periph_req_o,
  input  obi_resp_t periph_resp_i
);

  slave_sel_e        addr_sel;
  slave_sel_e        pending_sel_q;
  logic              pending_q;
  logic              none_rvalid_q;
  logic              slave_gnt;
  logic              master_gnt;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;

  // wrapping subtraction covers a region starting at zero
  function automatic logic in_region(input logic [ADDR_W-1:0] addr,
                                     input logic [ADDR_W-1:0] base,
                                     input logic [ADDR_W-1:0] size);
    return (addr - base) < size;
  endfunction

  always_comb begin
    if (in_region(master_req_i.addr, RAM_START, RAM_SIZE)) begin
      addr_sel = SEL_RAM;
    end else if (in_region(master_req_i.addr, SLOW_RAM_START, SLOW_RAM_SIZE)) begin
      addr_sel = SEL_SLOW;
    end else if (in_region(master_req_i.addr, PERIPH_START, PERIPH_SIZE)) begin
      addr_sel = SEL_PERIPH;
    end else begin
      addr_sel = SEL_NONE;
    end
  end

  // only the selected slave sees req, and only when nothing is pending
  always_comb begin
    ram_req_o       = master_req_i;
    ram_req_o.addr  = master_req_i.addr - RAM_START;
    ram_req_o.req   = master_req_i.req && !pending_q && (addr_sel == SEL_RAM);

    slow_req_o      = master_req_i;
    slow_req_o.addr = master_req_i.addr - SLOW_RAM_START;
    slow_req_o.req  = master_req_i.req && !pending_q && (addr_sel == SEL_SLOW);

    periph_req_o      = master_req_i;
    periph_req_o.addr = master_req_i.addr - PERIPH_START;
    periph_req_o.req  = master_req_i.req && !pending_q && (addr_sel == SEL_PERIPH);
  end

  always_comb begin
    unique case (addr_sel)
      SEL_RAM:    slave_gnt = ram_resp_i.gnt;
      SEL_SLOW:   slave_gnt = slow_resp_i.gnt;
      SEL_PERIPH: slave_gnt = periph_resp_i.gnt;
      default:    slave_gnt = 1'b1;
    endcase
  end

  assign master_gnt = master_req_i.req && !pending_q && slave_gnt;

  always_comb begin
    unique case (pending_sel_q)
      SEL_RAM: begin
        rsp_valid = ram_resp_i.rvalid;
        rsp_rdata = ram_resp_i.rdata;
      end
      SEL_SLOW: begin
        rsp_valid = slow_resp_i.rvalid;
        rsp_rdata = slow_resp_i.rdata;
      end
      SEL_PERIPH: begin
        rsp_valid = periph_resp_i.rvalid;
        rsp_rdata = periph_resp_i.rdata;
      end
      default: begin
        // unmapped space reads as zero
        rsp_valid = none_rvalid_q;
        rsp_rdata = '0;
      end
    endcase
  end

  assign master_resp_o.gnt    = master_gnt;
  assign master_resp_o.rvalid = pending_q && rsp_valid;
  assign master_resp_o.rdata  = rsp_rdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q     <= 1'b0;
      pending_sel_q <= SEL_NONE;
      none_rvalid_q <= 1'b0;
    end else begin
      none_rvalid_q <= master_gnt && (addr_sel == SEL_NONE);
      if (master_gnt) begin
        pending_q     <= 1'b1;
        pending_sel_q <= addr_sel;
      end else if (master_resp_o.rvalid) begin
        pending_q <= 1'b0;
      end
    end
  end

endmodule

// ==== src/sram_bank.sv ====
// single-cycle word memory with byte enables
// grant in the request cycle, rvalid one cycle later

module sram_bank
  import obi_pkg::*;
#(
  parameter int NUM_WORDS = 1024
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  localparam int IDX_W = $clog2(NUM_WORDS);

  logic [DATA_W-1:0] mem [NUM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  assign word_idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (req_i.be[i]) begin
          mem[word_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
    // writes answer with zero data
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== src/slow_memory.sv ====
// word memory with byte enables and a random grant delay
// 4-bit lfsr picks 0 to 3 wait cycles per request

module slow_memory
  import obi_pkg::*;
#(
  parameter int NUM_WORDS = 128
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  localparam int         IDX_W     = $clog2(NUM_WORDS);
  localparam logic [3:0] LFSR_SEED = 4'b1001;

  logic [DATA_W-1:0] mem [NUM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic [3:0]        lfsr_q;
  logic              busy_q;
  logic [1:0]        wait_q;
  logic [1:0]        cur_wait;
  logic              gnt;

  assign word_idx = req_i.addr[IDX_W+1:2];

  // fresh draw on a new request, otherwise the remaining count
  assign cur_wait = busy_q ? wait_q : lfsr_q[1:0];
  assign gnt      = req_i.req && (cur_wait == 2'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q   <= LFSR_SEED;
      busy_q   <= 1'b0;
      wait_q   <= 2'd0;
      rvalid_q <= 1'b0;
    end else begin
      // x^4 + x^3 + 1
      lfsr_q   <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      rvalid_q <= gnt;
      if (req_i.req && !gnt) begin
        busy_q <= 1'b1;
        wait_q <= cur_wait - 2'd1;
      end else begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (req_i.be[i]) begin
          mem[word_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
    if (gnt) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== src/exit_peripheral.sv ====
// exit value, sticky exit flag and scratch register on the bus

module exit_peripheral
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  obi_req_t          req_i,
  output obi_resp_t         resp_o,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  logic [DATA_W-1:0] exit_value_q;
  logic              exit_valid_q;
  logic [DATA_W-1:0] scratch_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic              wr_en;

  // whole-word writes, be is ignored
  assign wr_en = req_i.req && req_i.we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && req_i.addr == EXIT_VALUE_OFFSET) begin
        exit_value_q <= req_i.wdata;
      end
      // stays set until reset
      if (wr_en && req_i.addr == EXIT_VALID_OFFSET && req_i.wdata[0]) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && req_i.addr == SCRATCH_OFFSET) begin
      scratch_q <= req_i.wdata;
    end
    if (req_i.req) begin
      if (req_i.we) begin
        rdata_q <= '0;
      end else begin
        unique case (req_i.addr)
          EXIT_VALUE_OFFSET: rdata_q <= exit_value_q;
          EXIT_VALID_OFFSET: rdata_q <= {{(DATA_W-1){1'b0}}, exit_valid_q};
          SCRATCH_OFFSET:    rdata_q <= scratch_q;
          default:           rdata_q <= '0;
        endcase
      end
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;
  assign exit_value_o  = exit_value_q;
  assign exit_valid_o  = exit_valid_q;

endmodule

// ==== src/mini_mcu_top.sv ====
// top level with the system bus, sram, slow memory and exit peripheral
// data port stands in for the core's data master

module mini_mcu_top
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,

  input  obi_req_t          data_req_i,
  output obi_resp_t         data_resp_o,

  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  localparam int RAM_WORDS  = RAM_SIZE / BE_W;
  localparam int SLOW_WORDS = SLOW_RAM_SIZE / BE_W;

  obi_req_t  ram_slave_req;
  obi_resp_t ram_slave_resp;
  obi_req_t  slow_slave_req;
  obi_resp_t slow_slave_resp;
  obi_req_t  periph_slave_req;
  obi_resp_t periph_slave_resp;

  system_bus system_bus_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .master_req_i (data_req_i),
    .master_resp_o(data_resp_o),
    .ram_req_o    (ram_slave_req),
    .ram_resp_i   (ram_slave_resp),
    .slow_req_o   (slow_slave_req),
    .slow_resp_i  (slow_slave_resp),
    .periph_req_o (periph_slave_req),
    .periph_resp_i(periph_slave_resp)
  );

  sram_bank #(
    .NUM_WORDS(RAM_WORDS)
  ) sram_bank_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (ram_slave_req),
    .resp_o (ram_slave_resp)
  );

  slow_memory #(
    .NUM_WORDS(SLOW_WORDS)
  ) slow_ram_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (slow_slave_req),
    .resp_o (slow_slave_resp)
  );

  exit_peripheral exit_peripheral_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (periph_slave_req),
    .resp_o      (periph_slave_resp),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

// ==== tests/tb_mini_mcu.sv ====
// testbench for mini_mcu_top
// bus driver, reference model of the address map, compare tasks, timeout

module tb_mini_mcu
  import obi_pkg::*;
  import mcu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int T1_WORDS    = 16;
  localparam int T2_CASES    = 8;
  localparam int T3_WORDS    = 16;
  localparam int T3_OPS      = 40;
  localparam int T4_TXNS     = 6;
  localparam int T5_TXNS     = 14;
  localparam int NUM_TXN     = 2 * T1_WORDS + 3 * T2_CASES + T3_WORDS + T3_OPS
                               + T4_TXNS + T5_TXNS;
  localparam int CYCLE_LIMIT = 20 * NUM_TXN + 100;
  localparam int RVALID_WAIT = 8;

  localparam logic [3:0]  PART_BE [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
  localparam logic [31:0] UNMAPPED_ADDR [4] = '{32'h0000_1000, 32'h0001_0200,
                                                32'h0002_1000, 32'h3000_0000};
  // first word of each region, where a truncated unmapped address would land,
  // plus the last ram word
  localparam logic [31:0] NEIGHBOR_ADDR [4] = '{32'h0000_0000, 32'h0001_0000,
                                                32'h0002_0000, 32'h0000_0FFC};

  logic              clk = 1'b0;
  logic              reset;
  obi_req_t          data_req;
  obi_resp_t         data_resp;
  logic [DATA_W-1:0] exit_value;
  logic              exit_valid;

  int seed = 65;
  int errors;
  int resp_errors;
  int cycles;
  int test_num;
  int txn_count;

  // reference model
  logic [31:0] ram_model [logic [29:0]];
  logic [31:0] slow_model [logic [29:0]];
  logic [31:0] exit_value_m;
  logic        exit_valid_m;
  logic [31:0] scratch_m;
  logic [31:0] exp_data_q [$];
  logic [31:0] exp_addr_q [$];

  mini_mcu_top mini_mcu_top_i (
    .clk_i       (clk),
    .reset_i     (reset),
    .data_req_i  (data_req),
    .data_resp_o (data_resp),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid)
  );

  always #2 clk = ~clk;

  function automatic logic in_range(input logic [31:0] addr, input logic [31:0] base,
                                    input logic [31:0] size);
    return (addr >= base) && (addr < base + size);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) result[8*b +: 8] = wdata[8*b +: 8];
    end
    return result;
  endfunction

  // expected read data for any address
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - PERIPH_START;
    if (in_range(addr, RAM_START, RAM_SIZE)) begin
      return ram_model.exists(addr[31:2]) ? ram_model[addr[31:2]] : 32'h0;
    end else if (in_range(addr, SLOW_RAM_START, SLOW_RAM_SIZE)) begin
      return slow_model.exists(addr[31:2]) ? slow_model[addr[31:2]] : 32'h0;
    end else if (in_range(addr, PERIPH_START, PERIPH_SIZE)) begin
      if (off == EXIT_VALUE_OFFSET) return exit_value_m;
      if (off == EXIT_VALID_OFFSET) return {31'b0, exit_valid_m};
      if (off == SCRATCH_OFFSET) return scratch_m;
    end
    return 32'h0;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
    logic [31:0] off;
    off = addr - PERIPH_START;
    if (in_range(addr, RAM_START, RAM_SIZE)) begin
      ram_model[addr[31:2]] = merge_bytes(expected_read(addr), wdata, be);
    end else if (in_range(addr, SLOW_RAM_START, SLOW_RAM_SIZE)) begin
      slow_model[addr[31:2]] = merge_bytes(expected_read(addr), wdata, be);
    end else if (in_range(addr, PERIPH_START, PERIPH_SIZE)) begin
      // peripheral ignores byte enables
      if (off == EXIT_VALUE_OFFSET) exit_value_m = wdata;
      if (off == EXIT_VALID_OFFSET && wdata[0]) exit_valid_m = 1'b1;
      if (off == SCRATCH_OFFSET) scratch_m = wdata;
    end
  endtask

  // one transaction: hold req until gnt, then wait for rvalid
  task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    #0.5;
    data_req.req   = 1'b1;
    data_req.we    = we;
    data_req.addr  = addr;
    data_req.wdata = wdata;
    data_req.be    = be;
    @(negedge clk);
    while (!data_resp.gnt) @(negedge clk);
    // expectation queued at the granting edge
    @(posedge clk);
    exp_data_q.push_back(we ? 32'h0 : expected_read(addr));
    exp_addr_q.push_back(addr);
    if (we) model_write(addr, wdata, be);
    txn_count++;
    #0.5;
    data_req.req = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!data_resp.rvalid && waited < RVALID_WAIT) begin
      waited++;
      @(negedge clk);
    end
    if (!data_resp.rvalid) begin
      errors++;
      $display("no response came within %0d cycles for address %h", RVALID_WAIT, addr);
    end
    rdata = data_resp.rdata;
  endtask

  task automatic check_resp(input obi_resp_t resp, input logic [31:0] exp,
                            input logic [31:0] addr);
    if (resp.rdata !== exp) begin
      resp_errors++;
      $display("FAILED data_resp_o.rdata at %h: got %h expected %h", addr, resp.rdata, exp);
    end
  endtask

  task automatic check_exit(input logic [DATA_W-1:0] value, input logic valid,
                            input logic [DATA_W-1:0] exp_value, input logic exp_valid);
    if (value !== exp_value) begin
      errors++;
      $display("FAILED exit_value_o: got %h expected %h", value, exp_value);
    end
    if (valid !== exp_valid) begin
      errors++;
      $display("FAILED exit_valid_o: got %h expected %h", valid, exp_valid);
    end
  endtask

  task automatic finish_test(input string name, input int errors_at_start);
    int total;
    @(posedge clk);
    total = errors + resp_errors;
    test_num++;
    if (total == errors_at_start) $display("test %0d %s: ok", test_num, name);
    else $display("test %0d %s: %0d errors", test_num, name, total - errors_at_start);
  endtask

  // every rvalid must match exactly one granted transaction
  always @(negedge clk) begin
    if (!reset && data_resp.rvalid) begin
      if (exp_data_q.size() == 0) begin
        resp_errors++;
        $display("rvalid seen with no transaction outstanding");
      end else begin
        check_resp(data_resp, exp_data_q.pop_front(), exp_addr_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int          start;
    logic [31:0] data;
    logic [31:0] tmp;
    logic [31:0] addr;
    logic [31:0] rdata;
    reset        = 1'b1;
    data_req     = '0;
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    scratch_m    = '0;
    repeat (3) @(posedge clk);
    #0.5;
    reset = 1'b0;

    start = errors + resp_errors;
    for (int i = 0; i < T1_WORDS; i++) begin
      data = $random(seed);
      bus_xfer(1'b1, RAM_START + 4 * i, data, 4'hF, rdata);
    end
    for (int i = 0; i < T1_WORDS; i++) bus_xfer(1'b0, RAM_START + 4 * i, 32'h0, 4'hF, rdata);
    finish_test("sram random words", start);

    start = errors + resp_errors;
    for (int i = 0; i < T2_CASES; i++) begin
      addr = (i < 4) ? RAM_START + 32'h100 + 4 * i : SLOW_RAM_START + 32'h40 + 4 * i;
      data = $random(seed);
      bus_xfer(1'b1, addr, data, 4'hF, rdata);
      data = $random(seed);
      bus_xfer(1'b1, addr, data, PART_BE[i % 4], rdata);
      bus_xfer(1'b0, addr, 32'h0, 4'hF, rdata);
    end
    finish_test("partial byte enables", start);

    start = errors + resp_errors;
    for (int i = 0; i < T3_WORDS; i++) begin
      data = $random(seed);
      bus_xfer(1'b1, SLOW_RAM_START + 4 * i, data, 4'hF, rdata);
    end
    for (int i = 0; i < T3_OPS; i++) begin
      tmp  = $random(seed);
      data = $random(seed);
      addr = SLOW_RAM_START + {26'b0, tmp[3:0], 2'b00};
      bus_xfer(tmp[8], addr, data, tmp[7:4], rdata);
    end
    finish_test("slow memory random traffic", start);

    start = errors + resp_errors;
    @(negedge clk);
    check_exit(exit_value, exit_valid, 32'h0, 1'b0);
    bus_xfer(1'b0, PERIPH_START + EXIT_VALID_OFFSET, 32'h0, 4'hF, rdata);
    data = $random(seed);
    bus_xfer(1'b1, PERIPH_START + EXIT_VALUE_OFFSET, data, 4'hF, rdata);
    bus_xfer(1'b1, PERIPH_START + EXIT_VALID_OFFSET, 32'h1, 4'hF, rdata);
    @(negedge clk);
    check_exit(exit_value, exit_valid, data, 1'b1);
    tmp = $random(seed);
    bus_xfer(1'b1, PERIPH_START + SCRATCH_OFFSET, tmp, 4'hF, rdata);
    bus_xfer(1'b0, PERIPH_START + SCRATCH_OFFSET, 32'h0, 4'hF, rdata);
    bus_xfer(1'b0, PERIPH_START + EXIT_VALUE_OFFSET, 32'h0, 4'hF, rdata);
    finish_test("exit peripheral", start);

    start = errors + resp_errors;
    for (int j = 0; j < 2; j++) begin
      data = $random(seed);
      bus_xfer(1'b1, NEIGHBOR_ADDR[j], data, 4'hF, rdata);
    end
    for (int j = 0; j < 4; j++) begin
      data = $random(seed);
      bus_xfer(1'b0, UNMAPPED_ADDR[j], 32'h0, 4'hF, rdata);
      bus_xfer(1'b1, UNMAPPED_ADDR[j], data, 4'hF, rdata);
    end
    for (int j = 0; j < 4; j++) bus_xfer(1'b0, NEIGHBOR_ADDR[j], 32'h0, 4'hF, rdata);
    finish_test("unmapped space", start);

    $display("%0d tests, %0d transactions, %0d errors", test_num, txn_count,
             errors + resp_errors);
    if (errors + resp_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/obi_pkg.sv
src/mcu_pkg.sv
src/system_bus.sv
src/sram_bank.sv
src/slow_memory.sv
src/exit_peripheral.sv
src/mini_mcu_top.sv
tests/tb_mini_mcu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mini_mcu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_mini_mcu \
  -f tb.f \
  -o tb_mini_mcu_sim

./obj_dir/tb_mini_mcu_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
